//--- flist.f
source/exec_pkg.sv
source/operand_select.sv
source/alu.sv
source/serial_shifter.sv
source/shift_counter.sv
source/branch_unit.sv
source/exec_ctrl.sv
source/execute_stage.sv
sim/tb_clock.sv
sim/tb_execute_stage.sv

//--- sim/tb_execute_stage.sv
// Execute stage testbench
`timescale 1ns/100ps
`default_nettype none

module tb_execute_stage;

    import exec_pkg::*;

    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 34 + 50;  // Longest shift plus issue gap

    logic         clk;
    logic         rst;
    logic         issue;
    op_class_t    op_class;
    alu_op_t      alu_op;
    branch_cond_t branch_cond;
    logic         alu_src;
    word_t        rs1_value;
    word_t        rs2_value;
    word_t        imm;
    word_t        pc;
    reg_idx_t     rd;
    logic         mem_write_in;
    logic         mem_read_in;
    logic         reg_write_in;
    logic         busy;
    logic         done;
    word_t        result;
    logic         branch_taken;
    word_t        branch_target;
    logic         mem_write;
    logic         mem_read;
    logic         reg_write;
    reg_idx_t     reg_dest;

    logic [31:0] lfsr_state  = 32'd43;          // Shared random source
    int          error_count = 0;
    int          done_count  = 0;               // Done pulses seen at the falling edge
    int          cycle_count = 0;
    logic        real_issue  = 1'b0;            // High with the issue the DUT has to accept
    logic        in_flight   = 1'b0;            // Model of the busy window
    int          latency     = 0;               // Cycles since the accepting edge
    word_t       exp_result  = '0;
    logic        exp_taken   = 1'b0;
    word_t       exp_target  = '0;
    reg_idx_t    exp_reg_dest  = '0;
    logic        exp_mem_write = 1'b0;
    logic        exp_mem_read  = 1'b0;
    logic        exp_reg_write = 1'b0;
    int          exp_latency   = 1;

    tb_clock tb_clock_inst (.clk(clk));

    execute_stage execute_stage_inst (
        .clk(clk), .rst(rst), .issue(issue), .op_class(op_class), .alu_op(alu_op),
        .branch_cond(branch_cond), .alu_src(alu_src), .rs1_value(rs1_value),
        .rs2_value(rs2_value), .imm(imm), .pc(pc), .rd(rd), .mem_write_in(mem_write_in),
        .mem_read_in(mem_read_in), .reg_write_in(reg_write_in), .busy(busy), .done(done),
        .result(result), .branch_taken(branch_taken), .branch_target(branch_target),
        .mem_write(mem_write), .mem_read(mem_read), .reg_write(reg_write), .reg_dest(reg_dest)
    );

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        feedback;
        int          i;
        value = '0;
        for (i = 0; i < n; i++)
        begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic alu_op_t pick_alu_op(input logic [3:0] idx);
        case (idx % 10)
            0: return ADD;
            1: return SUB;
            2: return SLL;
            3: return SLT;
            4: return SLTU;
            5: return XOR;
            6: return SRL;
            7: return SRA;
            8: return OR;
            default: return AND;
        endcase
    endfunction

    function automatic word_t expected_op_a(input op_class_t cls, input word_t a, input word_t p);
        case (cls)
            LOAD_STORE, BRANCH, REG_IMM: return a;
            AUIPC, JAL, JALR:            return p;
            default:                     return '0;  // LUI builds on zero
        endcase
    endfunction

    function automatic word_t expected_op_b(input op_class_t cls, input logic src,
                                            input word_t b, input word_t i);
        case (cls)
            BRANCH:    return b;
            REG_IMM:   return src ? i : b;
            JAL, JALR: return 32'd4;             // Link is the next instruction
            default:   return i;
        endcase
    endfunction

    function automatic word_t expected_alu(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << b[4:0];
            SLT:     return {31'd0, $signed(a) < $signed(b)};
            SLTU:    return {31'd0, a < b};
            XOR:     return a ^ b;
            SRL:     return a >> b[4:0];
            SRA:     return word_t'($signed(a) >>> b[4:0]);
            OR:      return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic expected_taken(input op_class_t cls, input branch_cond_t cond,
                                            input word_t a, input word_t b);
        if (cls == JAL || cls == JALR)
            return 1'b1;
        if (cls != BRANCH)
            return 1'b0;
        case (cond)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            default: return a >= b;              // BGEU
        endcase
    endfunction

    task automatic record_failure(input string msg);
        error_count++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // One instruction from drive to completion, with an optional issue while busy
    task automatic run_instruction();
        logic [2:0]   cls_bits;
        logic [2:0]   cond_bits;
        op_class_t    cls;
        alu_op_t      op;
        branch_cond_t cond;
        word_t        a_val;
        word_t        b_val;
        word_t        i_val;
        word_t        p_val;
        word_t        opb;
        logic         src;
        logic [4:0]   dest;
        logic [2:0]   ctl;
        logic         inject;
        int           wanted;
        cls_bits  = 3'(take_bits(3));
        cls       = (cls_bits == 3'b110) ? REG_IMM : op_class_t'(cls_bits);
        op        = (cls == REG_IMM) ? pick_alu_op(4'(take_bits(4))) :
                    (cls == BRANCH) ? SUB : ADD;
        cond_bits = 3'(take_bits(3));
        cond      = (cond_bits[2:1] == 2'b01) ? BNE : branch_cond_t'(cond_bits);
        a_val     = take_bits(32);
        b_val     = (take_bits(2) == 0) ? a_val : take_bits(32);  // Equal operands now and then
        i_val     = take_bits(32);
        p_val     = take_bits(32) & ~32'd3;
        if (take_bits(2) == 0)
        begin
            i_val[4:0] = 5'd0;                  // Shift by zero path
            b_val[4:0] = 5'd0;
        end
        src    = 1'(take_bits(1));
        dest   = 5'(take_bits(5));
        ctl    = 3'(take_bits(3));
        inject = (take_bits(2) == 0);
        opb    = expected_op_b(cls, src, b_val, i_val);
        wanted = done_count + 1;

        @(posedge clk);
        issue         <= 1'b1;
        real_issue    <= 1'b1;
        op_class      <= cls;
        alu_op        <= op;
        branch_cond   <= cond;
        alu_src       <= src;
        rs1_value     <= a_val;
        rs2_value     <= b_val;
        imm           <= i_val;
        pc            <= p_val;
        rd            <= dest;
        mem_write_in  <= ctl[2];
        mem_read_in   <= ctl[1];
        reg_write_in  <= ctl[0];
        exp_result    <= expected_alu(op, expected_op_a(cls, a_val, p_val), opb);
        exp_taken     <= expected_taken(cls, cond, a_val, b_val);
        exp_target    <= (cls == JALR) ? ((a_val + i_val) & ~32'd1) : (p_val + i_val);
        exp_reg_dest  <= dest;
        exp_mem_write <= ctl[2];
        exp_mem_read  <= ctl[1];
        exp_reg_write <= ctl[0];
        exp_latency   <= ((op == SLL || op == SRL || op == SRA) && opb[4:0] != 5'd0) ?
                         int'(opb[4:0]) + 1 : 1;

        @(posedge clk);                         // DUT accepts on this edge
        issue      <= inject;
        real_issue <= 1'b0;
        if (inject)
        begin
            rd           <= ~dest;
            mem_write_in <= ~ctl[2];
            mem_read_in  <= ~ctl[1];
            reg_write_in <= ~ctl[0];
            @(posedge clk);
            issue        <= 1'b0;
            rd           <= dest;
            mem_write_in <= ctl[2];
            mem_read_in  <= ctl[1];
            reg_write_in <= ctl[0];
        end
        while (done_count < wanted)
            @(posedge clk);
    endtask

    // Busy window model, driven only by the accepted issue and the predicted latency
    always @(posedge clk)
    begin
        if (rst)
        begin
            in_flight <= 1'b0;
            latency   <= 0;
        end
        else if (real_issue)
        begin
            in_flight <= 1'b1;
            latency   <= 1;
        end
        else if (in_flight && latency == exp_latency)
            in_flight <= 1'b0;
        else if (in_flight)
            latency <= latency + 1;
    end

    always @(negedge clk)
    begin
        if (!rst && done)
            done_count++;                       // Sampled mid-cycle, away from both edges
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d of %0d instructions done",
                     cycle_count, done_count, NUM_INSTR);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    a_result : assert property (@(posedge clk) disable iff (rst) done |-> result == exp_result)
        else record_failure($sformatf("result %h, model %h",
                            $sampled(result), $sampled(exp_result)));

    a_branch : assert property (@(posedge clk) disable iff (rst)
        done |-> (branch_taken == exp_taken && branch_target == exp_target))
        else record_failure($sformatf("branch %b/%h, model %b/%h", $sampled(branch_taken),
                            $sampled(branch_target), $sampled(exp_taken), $sampled(exp_target)));

    a_controls : assert property (@(posedge clk) disable iff (rst)
        done |-> (reg_dest == exp_reg_dest && mem_write == exp_mem_write
                  && mem_read == exp_mem_read && reg_write == exp_reg_write))
        else record_failure("pass-through controls differ from the issued values");

    // Covers the latency of each instruction and the single-cycle pulse
    a_done_timing : assert property (@(posedge clk) disable iff (rst)
        done == (in_flight && latency == exp_latency))
        else record_failure($sformatf("done %b at latency %0d, expected latency %0d",
                            $sampled(done), $sampled(latency), $sampled(exp_latency)));

    a_busy : assert property (@(posedge clk) disable iff (rst) busy == in_flight)
        else record_failure($sformatf("busy %b, model %b",
                            $sampled(busy), $sampled(in_flight)));

    a_done_pulse : assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else record_failure("done longer than one cycle");

    // Rejected issues must not disturb the registered controls
    a_controls_hold : assert property (@(posedge clk) disable iff (rst)
        !real_issue |=> ($stable(reg_dest) && $stable(mem_write) && $stable(mem_read)
                         && $stable(reg_write)))
        else record_failure("controls changed without an accepted issue");

    a_data_hold : assert property (@(posedge clk) disable iff (rst)
        (!real_issue && !in_flight) |=> ($stable(result) && $stable(branch_taken)
                                         && $stable(branch_target)))
        else record_failure("result or branch outputs changed outside an instruction");

    a_reset_values : assert property (@(posedge clk)
        rst |-> (!busy && !done && !branch_taken && !mem_write && !mem_read && !reg_write
                 && result == '0 && branch_target == '0 && reg_dest == '0))
        else record_failure("outputs not at their reset values");

    initial
    begin
        rst          <= 1'b1;
        issue        <= 1'b0;
        op_class     <= LOAD_STORE;
        alu_op       <= ADD;
        branch_cond  <= BEQ;
        alu_src      <= 1'b0;
        rs1_value    <= '0;
        rs2_value    <= '0;
        imm          <= '0;
        pc           <= '0;
        rd           <= '0;
        mem_write_in <= 1'b0;
        mem_read_in  <= 1'b0;
        reg_write_in <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_INSTR; n++)
            run_instruction();
        repeat (3) @(posedge clk);
        $display("Errors: %0d, instructions completed: %0d of %0d",
                 error_count, done_count, NUM_INSTR);
        if (error_count == 0 && done_count == NUM_INSTR)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// Testbench clock source
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 10ns;         // 20 ns period

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// RV32I execute stage top level
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  exec_pkg::op_class_t    op_class,
    input  exec_pkg::alu_op_t      alu_op,
    input  exec_pkg::branch_cond_t branch_cond,
    input  logic                   alu_src,
    input  exec_pkg::word_t        rs1_value,
    input  exec_pkg::word_t        rs2_value,
    input  exec_pkg::word_t        imm,
    input  exec_pkg::word_t        pc,
    input  exec_pkg::reg_idx_t     rd,
    input  logic                   mem_write_in,
    input  logic                   mem_read_in,
    input  logic                   reg_write_in,
    output logic                   busy,
    output logic                   done,
    output exec_pkg::word_t        result,
    output logic                   branch_taken,
    output exec_pkg::word_t        branch_target,
    output logic                   mem_write,
    output logic                   mem_read,
    output logic                   reg_write,
    output exec_pkg::reg_idx_t     reg_dest
);

    import exec_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t shift_value;
    logic  load;                                // Shift start strobe
    logic  step;                                // One shifter step per cycle
    logic  capture;                             // Result and branch registers update
    logic  shift_sel;
    logic  zero_amount;
    logic  last_step;

    operand_select operand_select_inst (
        .op_class  (op_class),
        .alu_src   (alu_src),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (imm),
        .pc        (pc),
        .op_a      (op_a),
        .op_b      (op_b)
    );

    alu alu_inst (
        .clk         (clk),
        .rst         (rst),
        .alu_op      (alu_op),
        .op_a        (op_a),
        .op_b        (op_b),
        .shift_value (shift_value),
        .shift_sel   (shift_sel),
        .capture     (capture),
        .result      (result)
    );

    serial_shifter serial_shifter_inst (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .step        (step),
        .alu_op      (alu_op),
        .op_a        (op_a),
        .shift_value (shift_value)
    );

    // The amount is the low five bits of the second operand, register or immediate
    shift_counter shift_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .step        (step),
        .amount      (op_b[4:0]),
        .zero_amount (zero_amount),
        .last_step   (last_step)
    );

    branch_unit branch_unit_inst (
        .clk           (clk),
        .rst           (rst),
        .capture       (capture),
        .op_class      (op_class),
        .branch_cond   (branch_cond),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .imm           (imm),
        .pc            (pc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    exec_ctrl exec_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .alu_op       (alu_op),
        .zero_amount  (zero_amount),
        .last_step    (last_step),
        .rd           (rd),
        .mem_write_in (mem_write_in),
        .mem_read_in  (mem_read_in),
        .reg_write_in (reg_write_in),
        .load         (load),
        .step         (step),
        .capture      (capture),
        .shift_sel    (shift_sel),
        .busy         (busy),
        .done         (done),
        .reg_dest     (reg_dest),
        .mem_write    (mem_write),
        .mem_read     (mem_read),
        .reg_write    (reg_write)
    );

endmodule

`default_nettype wire

//--- source/exec_ctrl.sv
// Execute stage controller
`timescale 1ns/100ps
`default_nettype none

module exec_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue,
    input  exec_pkg::alu_op_t  alu_op,
    input  logic               zero_amount,
    input  logic               last_step,
    input  exec_pkg::reg_idx_t rd,
    input  logic               mem_write_in,
    input  logic               mem_read_in,
    input  logic               reg_write_in,
    output logic               load,
    output logic               step,
    output logic               capture,
    output logic               shift_sel,
    output logic               busy,
    output logic               done,
    output exec_pkg::reg_idx_t reg_dest,
    output logic               mem_write,
    output logic               mem_read,
    output logic               reg_write
);

    import exec_pkg::*;

    exec_state_t state;
    exec_state_t next_state;
    logic        accept;                        // Issue seen while the stage is free
    logic        is_shift;

    assign accept   = (state == IDLE) && issue;
    assign is_shift = alu_op inside {SLL, SRL, SRA};
    assign busy     = (state != IDLE);
    assign done     = (state == CAPTURE);       // Single cycle since CAPTURE always leaves

    always_comb
    begin
        next_state = state;
        load       = 1'b0;
        step       = 1'b0;
        capture    = 1'b0;
        shift_sel  = 1'b0;
        case (state)
            IDLE:
            begin
                if (issue && is_shift && !zero_amount)
                begin
                    load       = 1'b1;          // Shifter and counter take their operands
                    next_state = SHIFT;
                end
                else if (issue)
                begin
                    capture    = 1'b1;          // Single-cycle result lands on the issue edge
                    next_state = CAPTURE;
                end
            end
            SHIFT:
            begin
                step = 1'b1;
                if (last_step)
                begin
                    capture    = 1'b1;          // Last step and capture share one edge
                    shift_sel  = 1'b1;
                    next_state = CAPTURE;
                end
            end
            CAPTURE:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= IDLE;
            reg_dest  <= '0;
            mem_write <= 1'b0;
            mem_read  <= 1'b0;
            reg_write <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // Issues while busy are dropped and leave these untouched
            if (accept)
            begin
                reg_dest  <= rd;
                mem_write <= mem_write_in;
                mem_read  <= mem_read_in;
                reg_write <= reg_write_in;
            end
        end
    end

    // A shift in progress needs the operation to stay a shift until its capture
    a_shift_op_held : assert property (
        @(posedge clk) disable iff (rst)
        (state == SHIFT) |-> is_shift
    ) else $error("exec_ctrl: operation left the shift class during a shift");

endmodule

`default_nettype wire

//--- source/branch_unit.sv
// Branch and jump resolution
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,
    input  exec_pkg::op_class_t    op_class,
    input  exec_pkg::branch_cond_t branch_cond,
    input  exec_pkg::word_t        rs1_value,
    input  exec_pkg::word_t        rs2_value,
    input  exec_pkg::word_t        imm,
    input  exec_pkg::word_t        pc,
    output logic                   branch_taken,
    output exec_pkg::word_t        branch_target
);

    import exec_pkg::*;

    logic  cond_true;                           // Outcome of the compare named by branch_cond
    logic  taken_next;
    word_t target_next;
    word_t jalr_sum;                            // Register-relative jump address before alignment

    assign jalr_sum = rs1_value + imm;

    always_comb
    begin
        case (branch_cond)
            BEQ:     cond_true = (rs1_value == rs2_value);
            BNE:     cond_true = (rs1_value != rs2_value);
            BLT:     cond_true = ($signed(rs1_value) < $signed(rs2_value));
            BGE:     cond_true = ($signed(rs1_value) >= $signed(rs2_value));
            BLTU:    cond_true = (rs1_value < rs2_value);
            BGEU:    cond_true = (rs1_value >= rs2_value);
            default: cond_true = 1'b0;
        endcase

        // Every class other than JALR targets pc plus imm, taken or not
        target_next = pc + imm;
        case (op_class)
            BRANCH:  taken_next = cond_true;
            JAL:     taken_next = 1'b1;
            JALR:
            begin
                taken_next  = 1'b1;
                target_next = {jalr_sum[XLEN-1:1], 1'b0};  // Bit 0 cleared
            end
            default: taken_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            branch_taken  <= 1'b0;
            branch_target <= '0;
        end
        else if (capture)
        begin
            branch_taken  <= taken_next;
            branch_target <= target_next;
        end
    end

endmodule

`default_nettype wire

//--- source/shift_counter.sv
// Shift step counter
`timescale 1ns/100ps
`default_nettype none

module shift_counter (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic             step,
    input  exec_pkg::shamt_t amount,
    output logic             zero_amount,       // Issue-time test of the incoming amount
    output logic             last_step          // The pending step is the final one
);

    import exec_pkg::*;

    shamt_t count;                              // Steps still to be taken

    assign zero_amount = (amount == '0);
    assign last_step   = (count == shamt_t'(1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (load)
        begin
            count <= amount;
        end
        else if (step)
        begin
            count <= count - shamt_t'(1);
        end
    end

    // Stepping past zero would wrap and run 31 extra steps
    a_no_step_at_zero : assert property (
        @(posedge clk) disable iff (rst)
        step |-> (count != '0)
    ) else $error("shift_counter: step with no steps left");

endmodule

`default_nettype wire

//--- source/serial_shifter.sv
// Bit-serial shifter
`timescale 1ns/100ps
`default_nettype none

module serial_shifter (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,             // Start of a shift, takes op_a
    input  logic              step,             // Move the working word by one bit
    input  exec_pkg::alu_op_t alu_op,
    input  exec_pkg::word_t   op_a,
    output exec_pkg::word_t   shift_value
);

    import exec_pkg::*;

    word_t   work;                              // Word after the steps taken so far
    alu_op_t shift_op;                          // Direction kept from the load cycle

    // The output is one step ahead so the last step and the capture share an edge
    always_comb
    begin
        case (shift_op)
            SLL:     shift_value = {work[XLEN-2:0], 1'b0};
            SRL:     shift_value = {1'b0, work[XLEN-1:1]};
            SRA:     shift_value = {work[XLEN-1], work[XLEN-1:1]};  // Sign bit refills the top
            default: shift_value = work;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            work     <= '0;
            shift_op <= SLL;
        end
        else if (load)
        begin
            work     <= op_a;
            shift_op <= alu_op;                 // Later steps no longer need alu_op held
        end
        else if (step)
        begin
            work <= shift_value;
        end
    end

    a_load_step_excl : assert property (
        @(posedge clk) disable iff (rst)
        !(load && step)
    ) else $error("serial_shifter: load and step in the same cycle");

endmodule

`default_nettype wire

//--- source/alu.sv
// Single-cycle ALU with result register
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic              clk,
    input  logic              rst,
    input  exec_pkg::alu_op_t alu_op,
    input  exec_pkg::word_t   op_a,
    input  exec_pkg::word_t   op_b,
    input  exec_pkg::word_t   shift_value,      // Final word from the serial shifter
    input  logic              shift_sel,        // Take shift_value instead of the local result
    input  logic              capture,
    output exec_pkg::word_t   result
);

    import exec_pkg::*;

    word_t alu_value;                           // Combinational result of this cycle

    always_comb
    begin
        case (alu_op)
            ADD:  alu_value = op_a + op_b;
            SUB:  alu_value = op_a - op_b;
            SLT:  alu_value = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU: alu_value = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:  alu_value = op_a ^ op_b;
            OR:   alu_value = op_a | op_b;
            AND:  alu_value = op_a & op_b;
            // A shift only reaches here with a zero amount, so the word is unchanged
            SLL, SRL, SRA:
                alu_value = op_a;
            default:
                alu_value = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            result <= '0;
        end
        else if (capture)
        begin
            result <= shift_sel ? shift_value : alu_value;  // Holds until the next capture
        end
    end

    // The controller only routes the shifter when the held operation is a shift
    a_shift_sel_op : assert property (
        @(posedge clk) disable iff (rst)
        (capture && shift_sel) |-> (alu_op inside {SLL, SRL, SRA})
    ) else $error("alu: shifter result captured for a non-shift operation");

endmodule

`default_nettype wire

//--- source/operand_select.sv
// ALU operand selection
`timescale 1ns/100ps
`default_nettype none

module operand_select (
    input  exec_pkg::op_class_t op_class,
    input  logic                alu_src,        // High picks the immediate for REG_IMM
    input  exec_pkg::word_t     rs1_value,
    input  exec_pkg::word_t     rs2_value,
    input  exec_pkg::word_t     imm,
    input  exec_pkg::word_t     pc,
    output exec_pkg::word_t     op_a,
    output exec_pkg::word_t     op_b
);

    import exec_pkg::*;

    always_comb
    begin
        op_a = '0;
        op_b = '0;
        case (op_class)
            LOAD_STORE:
            begin
                op_a = rs1_value;               // Effective address is base plus offset
                op_b = imm;
            end
            BRANCH:
            begin
                op_a = rs1_value;
                op_b = rs2_value;
            end
            REG_IMM:
            begin
                op_a = rs1_value;
                op_b = alu_src ? imm : rs2_value;
            end
            LUI:
            begin
                op_a = '0;                      // Upper immediate goes straight to rd
                op_b = imm;
            end
            AUIPC:
            begin
                op_a = pc;
                op_b = imm;
            end
            // Both jumps write the return address, the target comes from branch_unit
            JAL, JALR:
            begin
                op_a = pc;
                op_b = LINK_OFFSET;
            end
            default:
            begin
                op_a = '0;                      // Unused class encoding
                op_b = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
// Execute stage shared definitions
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;                   // Data path width

    typedef logic [XLEN-1:0] word_t;            // Operand, PC, immediate and result word
    typedef logic [4:0]      reg_idx_t;         // Register file index
    typedef logic [4:0]      shamt_t;           // Shift amount taken from op_b

    localparam word_t LINK_OFFSET = 32'd4;      // Added to PC for the return address

    // Operand classes as issued by decode
    typedef enum logic [2:0] {
        LOAD_STORE = 3'b000,
        BRANCH     = 3'b001,
        REG_IMM    = 3'b010,
        JAL        = 3'b011,
        LUI        = 3'b100,
        AUIPC      = 3'b101,
        JALR       = 3'b111
    } op_class_t;

    // Bit 3 follows instruction bit 30 and the low bits follow funct3
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_op_t;

    // Branch conditions use the funct3 field directly
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,                         // Waiting for an issue pulse
        SHIFT   = 2'd1,                         // Serial shift in progress
        CAPTURE = 2'd2                          // Result registered and done raised
    } exec_state_t;

endpackage

`default_nettype wire
